// File: logic/rename_settings.svh
// register file sizes, zero register index and rename group width
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

////////////////////
// register files
////////////////////

// architectural register count, indices 0..31
`define ARF_SIZE 32

// physical tag count, tags 32..63 start out free
`define PRF_SIZE 64

// hardwired zero register, never renamed
`define ZERO_REG 31

////////////////////
// group width
////////////////////

// rename slots and commit slots per cycle
`define GROUP_WIDTH 2

`endif

// File: logic/reg_index_pkg.sv
// index types for architectural registers, physical tags, map tables and tag masks
`default_nettype none

`include "rename_settings.svh"

package reg_index_pkg;

	////////////////////
	// index widths
	////////////////////

	typedef logic [$clog2(`ARF_SIZE)-1:0] arch_idx_t;	// architectural register number
	typedef logic [$clog2(`PRF_SIZE)-1:0] phys_tag_t;	// physical register tag

	////////////////////
	// whole-file views
	////////////////////

	typedef logic [`PRF_SIZE-1:0] tag_mask_t;	// one bit per physical tag

	// mapping per architectural register, entry i is the tag of arch i
	typedef phys_tag_t [`ARF_SIZE-1:0] map_table_t;

endpackage

`default_nettype wire

// File: logic/rename_bus_pkg.sv
// packed structs for rename requests, rename responses and in-order commits
`default_nettype none

package rename_bus_pkg;

	import reg_index_pkg::*;

	////////////////////
	// front end
	////////////////////

	typedef struct packed {
		logic      valid;	// slot carries an instruction
		arch_idx_t src_a;	// first source operand
		arch_idx_t src_b;	// second source operand
		arch_idx_t dest;	// destination register
		logic      has_dest;	// instruction writes dest
	} rename_req_t;

	typedef struct packed {
		logic      valid;	// response belongs to an accepted slot
		phys_tag_t phys_a;	// tag holding src_a
		phys_tag_t phys_b;	// tag holding src_b
		phys_tag_t phys_dest;	// new tag, or current one if not renamed
		phys_tag_t old_dest;	// mapping of dest before this slot
		logic      renamed;	// slot took a fresh tag
	} rename_rsp_t;

	////////////////////
	// retirement
	////////////////////

	// built by the reorder buffer from a stored rename response
	typedef struct packed {
		logic      valid;	// slot retires this cycle
		arch_idx_t dest;	// architectural dest
		phys_tag_t phys_dest;	// tag that becomes committed
		phys_tag_t old_dest;	// tag released to the free list
		logic      renamed;	// only renamed slots touch the table
	} commit_t;

endpackage

`default_nettype wire

// File: logic/free_list.sv
// free tag bitmask with lowest-first allocation, commit return and flush rebuild
`timescale 1ns/1ps
`default_nettype none

`include "rename_settings.svh"

module free_list import reg_index_pkg::*; (
	input  wire logic                            clock,
	input  wire logic                            reset,
	input  wire logic [1:0]                      tag_need,	// tags wanted by the group
	input  wire logic                            alloc_take,	// group accepted, consume tags
	input  wire logic [`GROUP_WIDTH-1:0]         free_valid,	// per commit slot
	input  wire phys_tag_t [`GROUP_WIDTH-1:0]    free_tag,	// tags coming back from retire
	input  wire logic                            flush,
	input  wire map_table_t                      committed_map,
	output logic      [`GROUP_WIDTH-1:0][$bits(phys_tag_t)-1:0] alloc_tag,	// lowest two free
	output logic      [1:0]                      tags_available	// free count, saturated at 2
);

	// arch registers hold tags 0..31 out of reset, the rest are free
	localparam tag_mask_t reset_mask = {{(`PRF_SIZE-`ARF_SIZE){1'b1}}, {`ARF_SIZE{1'b0}}};

	tag_mask_t free_mask_q;	// bit set = tag free
	tag_mask_t free_mask_d;
	tag_mask_t rebuild_mask;	// complement of committed tags
	logic      found_lo;
	logic      found_hi;
	phys_tag_t tag_lo;
	phys_tag_t tag_hi;

	////////////////////
	// priority search
	////////////////////

	always_comb begin
		found_lo = 1'b0;
		found_hi = 1'b0;
		tag_lo   = '0;
		tag_hi   = '0;
		for (int i = 0; i < `PRF_SIZE; i++) begin	// scan upward, first two hits win
			if (free_mask_q[i]) begin
				if (!found_lo) begin
					tag_lo   = phys_tag_t'(i);
					found_lo = 1'b1;
				end else if (!found_hi) begin
					tag_hi   = phys_tag_t'(i);
					found_hi = 1'b1;
				end
			end
		end
	end

	assign alloc_tag[0]   = tag_lo;
	assign alloc_tag[1]   = tag_hi;
	assign tags_available = {found_hi, found_lo & ~found_hi};	// 0, 1 or 2+

	////////////////////
	// mask update
	////////////////////

	always_comb begin
		free_mask_d = free_mask_q;
		if (alloc_take) begin
			if (tag_need != 2'd0) free_mask_d[tag_lo] = 1'b0;	// first needing slot
			if (tag_need == 2'd2) free_mask_d[tag_hi] = 1'b0;	// second needing slot
		end
		for (int k = 0; k < `GROUP_WIDTH; k++) begin
			if (free_valid[k]) free_mask_d[free_tag[k]] = 1'b1;	// overwritten tags return
		end
	end

	// everything the committed table does not reference is free after a flush
	always_comb begin
		rebuild_mask = '1;
		for (int i = 0; i < `ARF_SIZE; i++) begin
			rebuild_mask[committed_map[i]] = 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			free_mask_q <= reset_mask;
		end else if (flush) begin
			free_mask_q <= rebuild_mask;	// speculative allocations dropped
		end else begin
			free_mask_q <= free_mask_d;
		end
	end

	////////////////////
	// checks
	////////////////////

	// rename side must never take more tags than were offered
	assert property (@(posedge clock) disable iff (reset)
		alloc_take |-> tags_available >= tag_need);

	// a tag handed back by retire has to be in use right now
	for (genvar k = 0; k < `GROUP_WIDTH; k++) begin : g_free_check
		assert property (@(posedge clock) disable iff (reset)
			free_valid[k] |-> !free_mask_q[free_tag[k]]);
	end

endmodule

`default_nettype wire

// File: logic/rename_map.sv
// speculative map table with source lookup, in-group bypass, dest rename and flush restore
`timescale 1ns/1ps
`default_nettype none

`include "rename_settings.svh"

module rename_map import reg_index_pkg::*, rename_bus_pkg::*; (
	input  wire logic                             clock,
	input  wire logic                             reset,
	input  wire rename_req_t [`GROUP_WIDTH-1:0]   rename_req,	// slot 0 is older
	input  wire logic                             flush,
	input  wire map_table_t                       committed_map,	// restore source
	input  wire phys_tag_t [`GROUP_WIDTH-1:0]     alloc_tag,	// lowest free tags
	input  wire logic [1:0]                       tags_available,
	output logic [1:0]                            tag_need,	// 0..2 tags this group
	output logic                                  alloc_take,
	output logic                                  rename_ready,	// whole group accepted
	output rename_rsp_t [`GROUP_WIDTH-1:0]        rename_rsp	// one cycle after accept
);

	localparam arch_idx_t zero_reg = arch_idx_t'(`ZERO_REG);
	localparam phys_tag_t zero_tag = phys_tag_t'(`ZERO_REG);

	map_table_t                     map_q;	// speculative arch -> tag
	map_table_t                     map_d;
	logic [`GROUP_WIDTH-1:0]        need;	// slot wants a fresh tag
	logic                           accept;
	phys_tag_t [`GROUP_WIDTH-1:0]   new_tag;	// tag granted per slot
	rename_rsp_t [`GROUP_WIDTH-1:0] rsp_d;
	rename_rsp_t [`GROUP_WIDTH-1:0] rsp_q;	// payload only
	logic [`GROUP_WIDTH-1:0]        rsp_valid_q;

	// table read with zero reg pinned and an optional older-slot forward
	function automatic phys_tag_t read_tag(
		input map_table_t table_in,
		input arch_idx_t  idx,
		input logic       fwd_en,
		input arch_idx_t  fwd_dest,
		input phys_tag_t  fwd_tag
	);
		if (idx == zero_reg) return zero_tag;	// never renamed
		if (fwd_en && idx == fwd_dest) return fwd_tag;	// written earlier in the group
		return table_in[idx];
	endfunction

	////////////////////
	// group control
	////////////////////

	always_comb begin
		for (int k = 0; k < `GROUP_WIDTH; k++) begin
			need[k] = rename_req[k].valid && rename_req[k].has_dest &&
				(rename_req[k].dest != zero_reg);
		end
	end

	assign tag_need     = {1'b0, need[0]} + {1'b0, need[1]};
	assign rename_ready = !flush && (tags_available >= tag_need);	// all or nothing
	assign accept       = rename_ready && (rename_req[0].valid || rename_req[1].valid);
	assign alloc_take   = accept && (tag_need != 2'd0);

	// slot 1 takes the second tag only if slot 0 already took the first
	assign new_tag[0] = alloc_tag[0];
	assign new_tag[1] = need[0] ? alloc_tag[1] : alloc_tag[0];

	////////////////////
	// lookup
	////////////////////

	always_comb begin
		// slot 0 sees the table as it was before this group
		rsp_d[0].valid    = accept && rename_req[0].valid;
		rsp_d[0].phys_a   = read_tag(map_q, rename_req[0].src_a, 1'b0, '0, '0);
		rsp_d[0].phys_b   = read_tag(map_q, rename_req[0].src_b, 1'b0, '0, '0);
		rsp_d[0].old_dest = read_tag(map_q, rename_req[0].dest, 1'b0, '0, '0);
		rsp_d[0].renamed  = need[0];
		rsp_d[0].phys_dest = need[0] ? new_tag[0] : rsp_d[0].old_dest;

		// slot 1 forwards slot 0's new tag on a dest match
		rsp_d[1].valid    = accept && rename_req[1].valid;
		rsp_d[1].phys_a   = read_tag(map_q, rename_req[1].src_a, need[0],
			rename_req[0].dest, new_tag[0]);
		rsp_d[1].phys_b   = read_tag(map_q, rename_req[1].src_b, need[0],
			rename_req[0].dest, new_tag[0]);
		rsp_d[1].old_dest = read_tag(map_q, rename_req[1].dest, need[0],
			rename_req[0].dest, new_tag[0]);	// same-dest pair chains here
		rsp_d[1].renamed  = need[1];
		rsp_d[1].phys_dest = need[1] ? new_tag[1] : rsp_d[1].old_dest;
	end

	////////////////////
	// table update
	////////////////////

	always_comb begin
		map_d = map_q;
		if (accept) begin
			for (int k = 0; k < `GROUP_WIDTH; k++) begin	// younger slot written last
				if (need[k]) map_d[rename_req[k].dest] = new_tag[k];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `ARF_SIZE; i++) begin
				map_q[i] <= phys_tag_t'(i);	// identity mapping
			end
		end else if (flush) begin
			map_q <= committed_map;	// roll back to retired state
		end else begin
			map_q <= map_d;
		end
	end

	////////////////////
	// response register
	////////////////////

	always_ff @(posedge clock) begin
		rsp_q <= rsp_d;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			rsp_valid_q <= '0;
		end else begin
			rsp_valid_q <= {rsp_d[1].valid, rsp_d[0].valid};
		end
	end

	always_comb begin
		rename_rsp = rsp_q;
		for (int k = 0; k < `GROUP_WIDTH; k++) begin
			rename_rsp[k].valid = rsp_valid_q[k];	// valid from the reset register
		end
	end

	// holds through renames and through restores from the committed table
	assert property (@(posedge clock) disable iff (reset)
		map_q[zero_reg] == zero_tag);

endmodule

`default_nettype wire

// File: logic/retire_map.sv
// committed map table updated by in-order commits, returning overwritten tags
`timescale 1ns/1ps
`default_nettype none

`include "rename_settings.svh"

module retire_map import reg_index_pkg::*, rename_bus_pkg::*; (
	input  wire logic                          clock,
	input  wire logic                          reset,
	input  wire commit_t [`GROUP_WIDTH-1:0]    commit,	// slot 0 older
	input  wire logic                          flush,
	output map_table_t                         committed_map,
	output logic [`GROUP_WIDTH-1:0]            free_valid,	// tag released per slot
	output phys_tag_t [`GROUP_WIDTH-1:0]       free_tag
);

	map_table_t                    table_q;	// architectural state in tags
	map_table_t [`GROUP_WIDTH:0]   stage;	// table after each commit slot
	logic [`GROUP_WIDTH-1:0]       commit_valid;

	////////////////////
	// commit chain
	////////////////////

	always_comb begin
		stage[0] = table_q;
		for (int k = 0; k < `GROUP_WIDTH; k++) begin
			stage[k+1]      = stage[k];
			commit_valid[k] = commit[k].valid;
			if (commit[k].valid && commit[k].renamed) begin
				stage[k+1][commit[k].dest] = commit[k].phys_dest;	// slot 1 sees slot 0
			end
			free_valid[k] = commit[k].valid && commit[k].renamed && !flush;
			free_tag[k]   = commit[k].old_dest;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `ARF_SIZE; i++) begin
				table_q[i] <= phys_tag_t'(i);	// same identity as the spec map
			end
		end else if (!flush) begin
			table_q <= stage[`GROUP_WIDTH];
		end
	end

	assign committed_map = table_q;

	////////////////////
	// checks
	////////////////////

	// flush rebuild reads the table, commits must wait a cycle
	assert property (@(posedge clock) disable iff (reset)
		flush |-> commit_valid == '0);

	// old tag recorded at rename must be what retirement holds now
	for (genvar k = 0; k < `GROUP_WIDTH; k++) begin : g_old_check
		assert property (@(posedge clock) disable iff (reset)
			commit[k].valid && commit[k].renamed |->
				stage[k][commit[k].dest] == commit[k].old_dest);
	end

endmodule

`default_nettype wire

// File: logic/rename_unit.sv
// rename stage top level joining free list, speculative map and retirement map
`timescale 1ns/1ps
`default_nettype none

`include "rename_settings.svh"

module rename_unit import reg_index_pkg::*, rename_bus_pkg::*; (
	input  wire logic                           clock,
	input  wire logic                           reset,
	input  wire rename_req_t [`GROUP_WIDTH-1:0] rename_req,
	input  wire commit_t [`GROUP_WIDTH-1:0]     commit,	// from the reorder buffer
	input  wire logic                           flush,
	output logic                                rename_ready,
	output rename_rsp_t [`GROUP_WIDTH-1:0]      rename_rsp
);

	logic [1:0]                   tag_need;	// map -> free list
	logic                         alloc_take;
	phys_tag_t [`GROUP_WIDTH-1:0] alloc_tag;	// free list -> map
	logic [1:0]                   tags_available;
	map_table_t                   committed_map;	// retire -> both
	logic [`GROUP_WIDTH-1:0]      free_valid;	// retire -> free list
	phys_tag_t [`GROUP_WIDTH-1:0] free_tag;

	////////////////////
	// tag producer
	////////////////////

	free_list free_list_i (
		.clock          (clock),
		.reset          (reset),
		.tag_need       (tag_need),
		.alloc_take     (alloc_take),
		.free_valid     (free_valid),
		.free_tag       (free_tag),
		.flush          (flush),
		.committed_map  (committed_map),
		.alloc_tag      (alloc_tag),
		.tags_available (tags_available)
	);

	////////////////////
	// live mappings
	////////////////////

	rename_map rename_map_i (
		.clock          (clock),
		.reset          (reset),
		.rename_req     (rename_req),
		.flush          (flush),
		.committed_map  (committed_map),
		.alloc_tag      (alloc_tag),
		.tags_available (tags_available),
		.tag_need       (tag_need),
		.alloc_take     (alloc_take),
		.rename_ready   (rename_ready),
		.rename_rsp     (rename_rsp)
	);

	////////////////////
	// commit consumer
	////////////////////

	retire_map retire_map_i (
		.clock         (clock),
		.reset         (reset),
		.commit        (commit),
		.flush         (flush),
		.committed_map (committed_map),
		.free_valid    (free_valid),
		.free_tag      (free_tag)
	);

endmodule

`default_nettype wire

// File: verification/rename_model.svh
// reference model of the speculative map, the retirement map and the free tag mask
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

map_table_t model_map;	// speculative arch -> tag
map_table_t model_retired;	// committed arch -> tag
tag_mask_t  model_free;	// bit set = tag free

task automatic model_reset();
	model_free = '0;
	for (int i = 0; i < `ARF_SIZE; i++) begin
		model_map[i]     = phys_tag_t'(i);	// identity out of reset
		model_retired[i] = phys_tag_t'(i);
	end
	for (int i = `ARF_SIZE; i < `PRF_SIZE; i++) begin
		model_free[i] = 1'b1;	// upper half starts free
	end
endtask

function automatic phys_tag_t model_lookup(input arch_idx_t r);
	if (r == arch_idx_t'(`ZERO_REG)) return phys_tag_t'(`ZERO_REG);	// pinned
	return model_map[r];
endfunction

function automatic logic model_needs_tag(input rename_req_t s);
	return s.valid && s.has_dest && (s.dest != arch_idx_t'(`ZERO_REG));
endfunction

function automatic int model_group_need(input rename_req_t [`GROUP_WIDTH-1:0] req);
	int n;
	n = 0;
	for (int k = 0; k < `GROUP_WIDTH; k++) begin
		if (model_needs_tag(req[k])) n++;
	end
	return n;
endfunction

function automatic int model_free_count();
	int n;
	n = 0;
	for (int i = 0; i < `PRF_SIZE; i++) begin
		if (model_free[i]) n++;
	end
	return n;
endfunction

function automatic phys_tag_t model_lowest_free();
	for (int i = 0; i < `PRF_SIZE; i++) begin
		if (model_free[i]) return phys_tag_t'(i);
	end
	return '0;
endfunction

// slots handled oldest first, so slot 1 sees what slot 0 wrote
task automatic model_rename(input rename_req_t [`GROUP_WIDTH-1:0] req,
		output rename_rsp_t [`GROUP_WIDTH-1:0] rsp);
	phys_tag_t tag;
	rsp = '0;
	for (int k = 0; k < `GROUP_WIDTH; k++) begin
		if (req[k].valid) begin
			rsp[k].valid     = 1'b1;
			rsp[k].phys_a    = model_lookup(req[k].src_a);	// before own write
			rsp[k].phys_b    = model_lookup(req[k].src_b);
			rsp[k].old_dest  = model_lookup(req[k].dest);
			rsp[k].phys_dest = rsp[k].old_dest;
			if (model_needs_tag(req[k])) begin
				tag                    = model_lowest_free();
				model_free[tag]        = 1'b0;
				model_map[req[k].dest] = tag;
				rsp[k].phys_dest       = tag;
				rsp[k].renamed         = 1'b1;
			end
		end
	end
endtask

task automatic model_commit(input commit_t c);
	if (c.valid && c.renamed) begin
		model_retired[c.dest] = c.phys_dest;
		model_free[c.old_dest] = 1'b1;	// usable from the next cycle
	end
endtask

task automatic model_flush();
	model_map  = model_retired;
	model_free = '1;
	for (int i = 0; i < `ARF_SIZE; i++) begin
		model_free[model_retired[i]] = 1'b0;	// held by committed state
	end
endtask

`endif

// File: verification/rename_unit_tb.sv
// rename stage testbench with clock, reset, random groups, commit queue, checks and watchdog
`timescale 1ns/1ps
`default_nettype none

`include "rename_settings.svh"

module rename_unit_tb import reg_index_pkg::*, rename_bus_pkg::*; ();

	localparam int stall_fill   = 24;
	localparam int stall_drain  = 32;
	localparam int total_cycles = 3 + 18 + 202 + 300 +
		(1 + stall_fill + 4 + stall_drain) + 300 + 2000;

	logic                           clock = 1'b0;
	logic                           reset;
	rename_req_t [`GROUP_WIDTH-1:0] rename_req;
	commit_t [`GROUP_WIDTH-1:0]     commit;
	logic                           flush;
	logic                           rename_ready;
	rename_rsp_t [`GROUP_WIDTH-1:0] rename_rsp;

	rename_rsp_t [`GROUP_WIDTH-1:0] exp_rsp;	// prediction for next cycle
	arch_idx_t [`GROUP_WIDTH-1:0]   exp_dest;
	logic                           exp_pending;	// a group went in last edge
	rename_rsp_t [`GROUP_WIDTH-1:0] seen_rsp;	// last sampled response
	logic                           group_held;	// refused group still driven
	commit_t                        commit_queue[$];	// renamed but not yet retired
	int                             error_count;
	int                             test_errors;
	int                             tests_run;
	int                             tests_failed;
	int                             accept_count;	// responses seen from the DUT
	int                             flush_count;
	int                             mark;
	string                          current_test;

	`include "rename_model.svh"

	rename_unit rename_unit_i (
		.clock        (clock),
		.reset        (reset),
		.rename_req   (rename_req),
		.commit       (commit),
		.flush        (flush),
		.rename_ready (rename_ready),
		.rename_rsp   (rename_rsp)
	);

	always #50 clock = ~clock;	// 100 ns period

	////////////////////
	// checking
	////////////////////

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %s %s: expected %0d, actual %0d", current_test, what,
				expected, actual);
			error_count++;
		end
	endtask

	task automatic report_failure(input string text);
		$display("%s: %s", current_test, text);
		error_count++;
	endtask

	task automatic begin_test(input string name);
		current_test = name;
		test_errors  = error_count;
	endtask

	task automatic end_test();
		tests_run++;
		if (error_count != test_errors) tests_failed++;
		$display("%s: finished with %0d errors", current_test, error_count - test_errors);
	endtask

	// mid-cycle compare, then model advance for the coming edge
	task automatic sample_cycle();
		logic    ready;
		logic    any_valid;
		commit_t entry;
		any_valid = rename_req[0].valid || rename_req[1].valid;
		for (int k = 0; k < `GROUP_WIDTH; k++) begin
			check_value($sformatf("slot %0d valid", k), 32'(exp_pending && exp_rsp[k].valid),
				32'(rename_rsp[k].valid));
			if (exp_pending && exp_rsp[k].valid) begin
				check_value("phys_a", 32'(exp_rsp[k].phys_a), 32'(rename_rsp[k].phys_a));
				check_value("phys_b", 32'(exp_rsp[k].phys_b), 32'(rename_rsp[k].phys_b));
				check_value("phys_dest", 32'(exp_rsp[k].phys_dest), 32'(rename_rsp[k].phys_dest));
				check_value("old_dest", 32'(exp_rsp[k].old_dest), 32'(rename_rsp[k].old_dest));
				check_value("renamed", 32'(exp_rsp[k].renamed), 32'(rename_rsp[k].renamed));
				entry.valid     = 1'b1;	// rob entry from the expected result
				entry.dest      = exp_dest[k];
				entry.phys_dest = exp_rsp[k].phys_dest;
				entry.old_dest  = exp_rsp[k].old_dest;
				entry.renamed   = exp_rsp[k].renamed;
				commit_queue.push_back(entry);
			end
		end
		seen_rsp = rename_rsp;
		if (rename_rsp[0].valid || rename_rsp[1].valid) accept_count++;
		ready = !flush && (model_free_count() >= model_group_need(rename_req));
		check_value("rename_ready", 32'(ready), 32'(rename_ready));
		exp_pending = ready && any_valid;
		group_held  = !ready && any_valid;
		if (exp_pending) begin
			model_rename(rename_req, exp_rsp);	// allocation sees pre-commit mask
			for (int k = 0; k < `GROUP_WIDTH; k++) begin
				exp_dest[k] = rename_req[k].dest;
			end
		end
		for (int k = 0; k < `GROUP_WIDTH; k++) begin
			model_commit(commit[k]);
		end
		if (flush) begin
			model_flush();
			commit_queue.delete();	// in-flight work discarded
			flush_count++;
		end
	endtask

	task automatic step();
		@(negedge clock);
		sample_cycle();
		@(posedge clock);
		#1;	// inputs change just after the edge
	endtask

	////////////////////
	// stimulus
	////////////////////

	function automatic arch_idx_t pick_reg(input int span);
		if ($urandom_range(7, 0) == 0) return arch_idx_t'(`ZERO_REG);	// zero reg now and then
		return arch_idx_t'(`ZERO_REG - $urandom_range(span - 1, 0));	// small span gives more hits
	endfunction

	task automatic random_group(input int span);
		int slots;
		int lone;
		slots = $urandom_range(2, 0);
		lone  = $urandom_range(1, 0);
		rename_req = '0;
		for (int k = 0; k < `GROUP_WIDTH; k++) begin
			rename_req[k].valid    = (slots == 2) || (slots == 1 && lone == k);
			rename_req[k].src_a    = pick_reg(span);
			rename_req[k].src_b    = pick_reg(span);
			rename_req[k].dest     = pick_reg(span);
			rename_req[k].has_dest = ($urandom_range(3, 0) != 0);
		end
	endtask

	task automatic two_dest_group();
		rename_req = '0;
		for (int k = 0; k < `GROUP_WIDTH; k++) begin
			rename_req[k].valid    = 1'b1;
			rename_req[k].src_a    = pick_reg(32);
			rename_req[k].src_b    = pick_reg(32);
			rename_req[k].dest     = arch_idx_t'($urandom_range(30, 0));	// always renames
			rename_req[k].has_dest = 1'b1;
		end
	endtask

	// oldest entries retire first and a flush never shares a cycle with commits
	task automatic draw_commits(input int commit_max, input int flush_pct);
		int n;
		flush  = 1'b0;
		commit = '0;
		if (flush_pct > 0 && $urandom_range(99, 0) < flush_pct) begin
			flush = 1'b1;
			return;
		end
		n = $urandom_range(commit_max, 0);
		for (int k = 0; k < n && commit_queue.size() > 0; k++) begin
			commit[k] = commit_queue.pop_front();
		end
	endtask

	task automatic random_cycles(input int n, input int span, input int commit_max,
			input int flush_pct);
		for (int i = 0; i < n; i++) begin
			if (!group_held) random_group(span);	// held group stays put
			draw_commits(commit_max, flush_pct);
			step();
		end
	endtask

	////////////////////
	// test sequence
	////////////////////

	initial begin
		void'($urandom(32'h7d8d7618));
		reset        = 1'b1;
		rename_req   = '0;
		commit       = '0;
		flush        = 1'b0;
		exp_pending  = 1'b0;
		group_held   = 1'b0;
		error_count  = 0;
		tests_run    = 0;
		tests_failed = 0;
		accept_count = 0;
		flush_count  = 0;
		model_reset();
		repeat (3) @(posedge clock);
		#1;
		reset = 1'b0;

		begin_test("reset state");
		for (int g = 0; g < 8; g++) begin
			rename_req = '0;
			rename_req[0].valid = 1'b1;
			rename_req[0].src_a = arch_idx_t'(4 * g);
			rename_req[0].src_b = arch_idx_t'(4 * g + 1);
			rename_req[1].valid = 1'b1;
			rename_req[1].src_a = arch_idx_t'(4 * g + 2);
			rename_req[1].src_b = arch_idx_t'(4 * g + 3);
			step();
			rename_req = '0;
			step();
			check_value("identity a0", 4 * g, 32'(seen_rsp[0].phys_a));
			check_value("identity b0", 4 * g + 1, 32'(seen_rsp[0].phys_b));
			check_value("identity a1", 4 * g + 2, 32'(seen_rsp[1].phys_a));
			check_value("identity b1", 4 * g + 3, 32'(seen_rsp[1].phys_b));
		end
		rename_req[0] = '{valid: 1'b1, src_a: '0, src_b: '0, dest: 5'd3, has_dest: 1'b1};
		rename_req[1] = '{valid: 1'b1, src_a: '0, src_b: '0, dest: 5'd7, has_dest: 1'b1};
		step();
		rename_req = '0;
		step();
		check_value("first tag", 32, 32'(seen_rsp[0].phys_dest));
		check_value("second tag", 33, 32'(seen_rsp[1].phys_dest));
		end_test();

		begin_test("lookup and bypass");
		rename_req[0] = '{valid: 1'b1, src_a: 5'd1, src_b: 5'd2, dest: 5'd4, has_dest: 1'b1};
		rename_req[1] = '{valid: 1'b1, src_a: 5'd4, src_b: 5'd31, dest: 5'd4, has_dest: 1'b1};
		step();
		rename_req = '0;
		step();
		check_value("bypassed src", 34, 32'(seen_rsp[1].phys_a));	// tags 32, 33 already out
		check_value("zero src", `ZERO_REG, 32'(seen_rsp[1].phys_b));
		check_value("chained old tag", 34, 32'(seen_rsp[1].old_dest));
		check_value("younger tag", 35, 32'(seen_rsp[1].phys_dest));
		random_cycles(200, 4, 2, 0);	// few regs give lots of bypass
		end_test();

		begin_test("tag allocation");
		random_cycles(300, 32, 2, 0);
		end_test();

		begin_test("stall on empty free list");
		rename_req = '0;	// flush squashes any held group
		commit     = '0;
		flush      = 1'b1;	// empty queue leaves 32 free tags
		step();
		flush = 1'b0;
		for (int i = 0; i < stall_fill && !group_held; i++) begin
			two_dest_group();
			step();
		end
		if (!group_held || rename_ready) begin
			report_failure("rename_ready never dropped with the free list drained");
		end
		for (int i = 0; i < 4; i++) begin
			step();	// held group gets no response
		end
		mark = accept_count;
		for (int i = 0; i < stall_drain; i++) begin
			if (!group_held) rename_req = '0;
			draw_commits(2, 0);
			step();
		end
		if (accept_count == mark) report_failure("renaming did not resume after commits");
		end_test();

		begin_test("flush recovery");
		mark = flush_count;
		random_cycles(300, 8, 2, 6);
		if (flush_count == mark) report_failure("no flush was issued");
		end_test();

		begin_test("long random run");
		random_cycles(2000, 32, 2, 1);
		end_test();

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			error_count);
		if (error_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	initial begin
		#((total_cycles + 100) * 100);
		$display("watchdog: run did not end within %0d cycles", total_cycles + 100);
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+logic
+incdir+verification
logic/reg_index_pkg.sv
logic/rename_bus_pkg.sv
logic/free_list.sv
logic/rename_map.sv
logic/retire_map.sv
logic/rename_unit.sv
verification/rename_unit_tb.sv

// File: run.sh
#!/bin/sh
# build and run the rename stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f flist.f --top-module rename_unit_tb \
	-Mdir obj_dir -o rename_unit_sim || exit 1
out=$(./obj_dir/rename_unit_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Test OK" && echo "PASS" || { echo "FAIL"; exit 1; }
